// File: verilog/rdx_pkg.sv
//////////////////////////////////////////////////
// Shared register map, AXI response codes and status word
// for the read exerciser RTL
//////////////////////////////////////////////////

package rdx_pkg;

    // AXI4-Lite address width of the register block
    localparam int CSR_ADDR_W = 8;

    // Register byte offsets
    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL    = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] CSR_KEY     = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] CSR_TIMEOUT = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] CSR_STATUS  = 8'h0C;
    localparam logic [CSR_ADDR_W-1:0] CSR_BEATS   = 8'h10;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERRORS  = 8'h14;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Status register, read by software as one word
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [28:0] rsvd;
            logic        rdata_err;
            logic        rid_err;
            logic        timeout;
        } f;
    } rdx_status_u;

endpackage

// File: verilog/lfsr32.sv
//////////////////////////////////////////////////
// 32-bit Galois LFSR used for random scheduling,
// loads KEY on reset and steps while en is high
//////////////////////////////////////////////////

`timescale 1ns/10ps

module lfsr32 #(
    parameter logic [31:0] KEY = 32'h2834_6450
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        en,
    output logic [31:0] lfsr
);

    // Taps of x^32 + x^30 + x^26 + x^25 + 1, right-shifting form
    localparam logic [31:0] TAPS = 32'hA300_0000;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr <= KEY;
        end else if (en) begin
            lfsr <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? TAPS : 32'h0);
        end
    end

    // All-zero state would lock the sequence for good
    a_never_zero: assert property (
        @(posedge aclk) disable iff (!aresetn) lfsr != 32'h0
    );

endmodule

// File: verilog/rd_traffic_driver.sv
//////////////////////////////////////////////////
// AXI read master issuing random single-beat reads and
// checking each completion for ID, data and age
//////////////////////////////////////////////////

`timescale 1ns/10ps

module rd_traffic_driver import rdx_pkg::*; #(
    parameter int          ADDR_W   = 12,
    parameter int          ID_W     = 4,
    parameter int          MAX_OR   = 8,
    parameter logic [31:0] LFSR_KEY = 32'h1d87_2b41
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              en,
    input  logic              clr,
    input  logic [31:0]       key,
    input  logic [15:0]       timeout,
    output logic              cpl,
    output logic              err_timeout,
    output logic              err_rid,
    output logic              err_rdata,
    output logic              arvalid,
    input  logic              arready,
    output logic [ADDR_W-1:0] araddr,
    output logic [ID_W-1:0]   arid,
    input  logic              rvalid,
    output logic              rready,
    input  logic [ID_W-1:0]   rid,
    input  logic [31:0]       rdata,
    input  logic [1:0]        rresp
);

    localparam int PTR_W = (MAX_OR > 1) ? $clog2(MAX_OR) : 1;

    logic [31:0]       ar_lfsr;
    logic [31:0]       r_lfsr;
    logic              ar_hs;
    logic              r_hs;
    logic              restart;
    logic [3:0]        beat_cnt;
    logic [3:0]        batch_len;
    logic [31:0]       addr_word;
    logic [PTR_W-1:0]  req_ptr;
    logic [PTR_W-1:0]  cpl_ptr;
    logic [MAX_OR-1:0] busy;
    logic [MAX_OR-1:0] fired;
    logic [15:0]       age     [MAX_OR];
    logic [ID_W-1:0]   id_tab  [MAX_OR];
    logic [31:0]       exp_tab [MAX_OR];

    assign ar_hs     = arvalid && arready;
    assign r_hs      = rvalid && rready;
    assign addr_word = 32'(araddr);

    lfsr32 #(.KEY(LFSR_KEY)) u_ar_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (1'b1),
        .lfsr    (ar_lfsr)
    );

    lfsr32 #(.KEY({LFSR_KEY[15:0], LFSR_KEY[31:16]})) u_r_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (1'b1),
        .lfsr    (r_lfsr)
    );

    //////////////////////////////////////////////////
    // Request generation
    //////////////////////////////////////////////////

    // Raised at random, only into a free slot, and held until accepted
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            arvalid <= 1'b0;
        end else if (ar_hs) begin
            arvalid <= 1'b0;
        end else if (!arvalid && en && !busy[req_ptr] && (ar_lfsr[0] | ar_lfsr[1])) begin
            arvalid <= 1'b1;
        end
    end

    // Clear restarts the address sequence once no request is pending
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            restart   <= 1'b0;
            araddr    <= '0;
            arid      <= '0;
            beat_cnt  <= 4'd0;
            batch_len <= 4'd7;
        end else begin
            restart <= (clr || restart) && arvalid;
            if ((clr || restart) && !arvalid) begin
                araddr    <= '0;
                arid      <= '0;
                beat_cnt  <= 4'd0;
                batch_len <= 4'd7;
            end else if (ar_hs) begin
                if (beat_cnt == batch_len) begin
                    // New batch at a random word
                    araddr    <= {ar_lfsr[ADDR_W-1:2], 2'b00};
                    arid      <= arid + 1'b1;
                    batch_len <= ar_lfsr[7:4];
                    beat_cnt  <= 4'd0;
                end else begin
                    araddr   <= araddr + ADDR_W'(4);
                    beat_cnt <= beat_cnt + 4'd1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Outstanding table and completion checks
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            id_tab[req_ptr]  <= arid;
            exp_tab[req_ptr] <= key ^ (addr_word << 8) ^ addr_word;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rready      <= 1'b0;
            req_ptr     <= '0;
            cpl_ptr     <= '0;
            busy        <= '0;
            fired       <= '0;
            cpl         <= 1'b0;
            err_rid     <= 1'b0;
            err_rdata   <= 1'b0;
            err_timeout <= 1'b0;
            for (int i = 0; i < MAX_OR; i++) begin
                age[i] <= 16'd0;
            end
        end else begin
            rready      <= r_lfsr[0] | r_lfsr[2];
            cpl         <= r_hs;
            err_rid     <= r_hs && (rid != id_tab[cpl_ptr]);
            err_rdata   <= r_hs && ((rdata != exp_tab[cpl_ptr]) || (rresp != RESP_OKAY));
            err_timeout <= 1'b0;
            if (ar_hs) begin
                req_ptr <= (req_ptr == PTR_W'(MAX_OR - 1)) ? '0 : req_ptr + 1'b1;
            end
            if (r_hs) begin
                cpl_ptr <= (cpl_ptr == PTR_W'(MAX_OR - 1)) ? '0 : cpl_ptr + 1'b1;
            end
            for (int i = 0; i < MAX_OR; i++) begin
                if (ar_hs && req_ptr == PTR_W'(i)) begin
                    busy[i]  <= 1'b1;
                    fired[i] <= 1'b0;
                    age[i]   <= 16'd0;
                end else if (r_hs && cpl_ptr == PTR_W'(i)) begin
                    busy[i] <= 1'b0;
                end else if (busy[i]) begin
                    // Age keeps counting under back-pressure, fires once per request
                    if (age[i] != 16'hFFFF) begin
                        age[i] <= age[i] + 16'd1;
                    end
                    if (age[i] == timeout && !fired[i]) begin
                        fired[i]    <= 1'b1;
                        err_timeout <= 1'b1;
                    end
                end
            end
        end
    end

    // A response with nothing outstanding means the target invented it
    a_no_orphan_r: assert property (
        @(posedge aclk) disable iff (!aresetn) rvalid |-> |busy
    );

    a_ar_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid)
    );

endmodule

// File: verilog/rd_pattern_mem.sv
//////////////////////////////////////////////////
// AXI read target returning address-derived pattern data
// in order, after a random latency of 1 to 8 cycles
//////////////////////////////////////////////////

`timescale 1ns/10ps

module rd_pattern_mem import rdx_pkg::*; #(
    parameter int          ADDR_W   = 12,
    parameter int          ID_W     = 4,
    parameter int          MAX_OR   = 8,
    parameter logic [31:0] MEM_KEY  = 32'h2834_6450,
    parameter logic [31:0] LFSR_KEY = 32'h1d87_2b41
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic [ID_W-1:0]   arid,
    output logic              rvalid,
    input  logic              rready,
    output logic [ID_W-1:0]   rid,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp
);

    localparam int PTR_W = (MAX_OR > 1) ? $clog2(MAX_OR) : 1;
    localparam int CNT_W = $clog2(MAX_OR + 1);

    logic [ADDR_W-1:0] q_addr [MAX_OR];
    logic [ID_W-1:0]   q_id   [MAX_OR];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [2:0]        wait_cnt;
    logic [31:0]       lat_lfsr;
    logic [31:0]       head_addr;
    logic              push;
    logic              pop;

    assign arready   = (count != CNT_W'(MAX_OR));
    assign push      = arvalid && arready;
    // Head moves to the output once its wait is over and the slot is free
    assign pop       = (count != '0) && (wait_cnt == 3'd0) && (!rvalid || rready);
    assign head_addr = 32'(q_addr[rd_ptr]);
    assign rresp     = RESP_OKAY;

    lfsr32 #(.KEY({LFSR_KEY[23:0], LFSR_KEY[31:24]})) u_lat_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (pop),
        .lfsr    (lat_lfsr)
    );

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wait_cnt <= 3'd0;
            rvalid   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(MAX_OR - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr   <= (rd_ptr == PTR_W'(MAX_OR - 1)) ? '0 : rd_ptr + 1'b1;
                wait_cnt <= lat_lfsr[2:0];
            end else if (count != '0 && wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (pop) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            q_addr[wr_ptr] <= araddr;
            q_id[wr_ptr]   <= arid;
        end
        if (pop) begin
            rid   <= q_id[rd_ptr];
            rdata <= MEM_KEY ^ (head_addr << 8) ^ head_addr;
        end
    end

    a_r_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid)
    );

endmodule

// File: verilog/rdx_csr.sv
//////////////////////////////////////////////////
// AXI4-Lite register block steering the read driver and
// collecting its status flags and counters
//////////////////////////////////////////////////

`timescale 1ns/10ps

module rdx_csr import rdx_pkg::*; #(
    parameter logic [31:0] MEM_KEY = 32'h2834_6450
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  logic [CSR_ADDR_W-1:0] s_axil_awaddr,
    input  logic [2:0]            s_axil_awprot,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    input  logic [31:0]           s_axil_wdata,
    input  logic [3:0]            s_axil_wstrb,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    output logic [1:0]            s_axil_bresp,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    input  logic [CSR_ADDR_W-1:0] s_axil_araddr,
    input  logic [2:0]            s_axil_arprot,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    output logic [31:0]           s_axil_rdata,
    output logic [1:0]            s_axil_rresp,
    output logic                  en,
    output logic                  clr,
    output logic [31:0]           key,
    output logic [15:0]           timeout,
    output logic                  error,
    input  logic                  cpl,
    input  logic                  err_timeout,
    input  logic                  err_rid,
    input  logic                  err_rdata
);

    logic        busy;
    logic        wr_hs;
    logic        rd_hs;
    logic        wr_ok;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;
    logic [31:0] beats;
    logic [31:0] errors;
    logic [1:0]  err_inc;
    logic [32:0] err_sum;
    rdx_status_u status;

    assign busy  = s_axil_awready | s_axil_arready | s_axil_bvalid | s_axil_rvalid;
    assign wr_hs = s_axil_awvalid & s_axil_awready & s_axil_wvalid & s_axil_wready;
    assign rd_hs = s_axil_arvalid & s_axil_arready;
    // Instruction-type accesses are refused
    assign wr_ok = !s_axil_awprot[2] && (s_axil_awaddr inside
                   {CSR_CTRL, CSR_KEY, CSR_TIMEOUT, CSR_STATUS, CSR_BEATS, CSR_ERRORS});

    //////////////////////////////////////////////////
    // Handshakes, one transaction at a time
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            s_axil_bresp   <= RESP_OKAY;
            s_axil_rresp   <= RESP_OKAY;
        end else begin
            // Reads win over writes
            s_axil_arready <= s_axil_arvalid && !busy;
            s_axil_awready <= s_axil_awvalid && s_axil_wvalid && !s_axil_arvalid && !busy;
            s_axil_wready  <= s_axil_awvalid && s_axil_wvalid && !s_axil_arvalid && !busy;
            if (rd_hs) begin
                s_axil_rvalid <= 1'b1;
                s_axil_rresp  <= rd_resp;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
            if (wr_hs) begin
                s_axil_bvalid <= 1'b1;
                s_axil_bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_data = 32'h0;
        rd_resp = s_axil_arprot[2] ? RESP_SLVERR : RESP_OKAY;
        case (s_axil_araddr)
            CSR_CTRL:    rd_data = {31'h0, en};
            CSR_KEY:     rd_data = key;
            CSR_TIMEOUT: rd_data = {16'h0, timeout};
            CSR_STATUS:  rd_data = status.raw;
            CSR_BEATS:   rd_data = beats;
            CSR_ERRORS:  rd_data = errors;
            default:     rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rd_hs) begin
            s_axil_rdata <= rd_data;
        end
    end

    //////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            en      <= 1'b0;
            clr     <= 1'b0;
            key     <= MEM_KEY;
            timeout <= 16'd64;
        end else begin
            clr <= 1'b0;
            if (wr_hs && !s_axil_awprot[2]) begin
                case (s_axil_awaddr)
                    CSR_CTRL: begin
                        if (s_axil_wstrb[0]) begin
                            en  <= s_axil_wdata[0];
                            clr <= s_axil_wdata[1];
                        end
                    end
                    CSR_KEY: begin
                        for (int b = 0; b < 4; b++) begin
                            if (s_axil_wstrb[b]) key[8*b +: 8] <= s_axil_wdata[8*b +: 8];
                        end
                    end
                    CSR_TIMEOUT: begin
                        for (int b = 0; b < 2; b++) begin
                            if (s_axil_wstrb[b]) timeout[8*b +: 8] <= s_axil_wdata[8*b +: 8];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Status flags and counters
    //////////////////////////////////////////////////

    assign err_inc = 2'(err_timeout) + 2'(err_rid) + 2'(err_rdata);
    assign err_sum = {1'b0, errors} + 33'(err_inc);
    assign error   = status.f.timeout | status.f.rid_err | status.f.rdata_err;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            beats      <= 32'h0;
            errors     <= 32'h0;
            status.raw <= 32'h0;
        end else if (clr) begin
            beats      <= 32'h0;
            errors     <= 32'h0;
            status.raw <= 32'h0;
        end else begin
            if (cpl && beats != 32'hFFFF_FFFF) begin
                beats <= beats + 32'd1;
            end
            // Saturate instead of wrapping
            errors <= err_sum[32] ? 32'hFFFF_FFFF : err_sum[31:0];
            if (err_timeout) status.f.timeout   <= 1'b1;
            if (err_rid)     status.f.rid_err   <= 1'b1;
            if (err_rdata)   status.f.rdata_err <= 1'b1;
        end
    end

    a_b_after_write: assert property (
        @(posedge aclk) disable iff (!aresetn) $rose(s_axil_bvalid) |-> $past(wr_hs)
    );

endmodule

// File: verilog/rdx_top.sv
//////////////////////////////////////////////////
// Read exerciser top: register block, traffic driver
// and pattern memory behind one AXI4-Lite port
//////////////////////////////////////////////////

`timescale 1ns/10ps

module rdx_top import rdx_pkg::*; #(
    parameter int          ADDR_W   = 12,
    parameter int          ID_W     = 4,
    parameter int          MAX_OR   = 8,
    parameter logic [31:0] MEM_KEY  = 32'h2834_6450,
    parameter logic [31:0] LFSR_KEY = 32'h1d87_2b41
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  logic [CSR_ADDR_W-1:0] s_axil_awaddr,
    input  logic [2:0]            s_axil_awprot,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    input  logic [31:0]           s_axil_wdata,
    input  logic [3:0]            s_axil_wstrb,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    output logic [1:0]            s_axil_bresp,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    input  logic [CSR_ADDR_W-1:0] s_axil_araddr,
    input  logic [2:0]            s_axil_arprot,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    output logic [31:0]           s_axil_rdata,
    output logic [1:0]            s_axil_rresp,
    output logic                  error
);

    logic              en;
    logic              clr;
    logic [31:0]       key;
    logic [15:0]       timeout;
    logic              cpl;
    logic              err_timeout;
    logic              err_rid;
    logic              err_rdata;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic [ID_W-1:0]   arid;
    logic              rvalid;
    logic              rready;
    logic [ID_W-1:0]   rid;
    logic [31:0]       rdata;
    logic [1:0]        rresp;

    rdx_csr #(.MEM_KEY(MEM_KEY)) u_csr (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awprot  (s_axil_awprot),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arprot  (s_axil_arprot),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .en             (en),
        .clr            (clr),
        .key            (key),
        .timeout        (timeout),
        .error          (error),
        .cpl            (cpl),
        .err_timeout    (err_timeout),
        .err_rid        (err_rid),
        .err_rdata      (err_rdata)
    );

    rd_traffic_driver #(
        .ADDR_W   (ADDR_W),
        .ID_W     (ID_W),
        .MAX_OR   (MAX_OR),
        .LFSR_KEY (LFSR_KEY)
    ) u_driver (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .en          (en),
        .clr         (clr),
        .key         (key),
        .timeout     (timeout),
        .cpl         (cpl),
        .err_timeout (err_timeout),
        .err_rid     (err_rid),
        .err_rdata   (err_rdata),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arid        (arid),
        .rvalid      (rvalid),
        .rready      (rready),
        .rid         (rid),
        .rdata       (rdata),
        .rresp       (rresp)
    );

    rd_pattern_mem #(
        .ADDR_W   (ADDR_W),
        .ID_W     (ID_W),
        .MAX_OR   (MAX_OR),
        .MEM_KEY  (MEM_KEY),
        .LFSR_KEY (LFSR_KEY)
    ) u_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arid    (arid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule

// File: sim/tb_clkgen.sv
//////////////////////////////////////////////////
// Testbench clock (10 ns) and active-low reset held for 2 cycles
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clkgen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Released just after the second rising edge
    initial begin
        aresetn = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;
    end

endmodule

// File: sim/tb_rdx.sv
//////////////////////////////////////////////////
// Testbench for the read exerciser, drives the register port
// and checks register values and the error output
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_rdx import rdx_pkg::*;;

    localparam logic [31:0] MEM_KEY = 32'h2834_6450;
    // Three runs of at most 400 cycles, about 60 register accesses
    // and the drain polling stay far below this
    localparam int MAX_CYCLES = 6000;

    logic        aclk;
    logic        aresetn;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [7:0]  s_axil_awaddr;
    logic [2:0]  s_axil_awprot;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [7:0]  s_axil_araddr;
    logic [2:0]  s_axil_arprot;
    logic        s_axil_rvalid;
    logic        s_axil_rready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        error;
    logic        clean_run;
    int          cycles;
    int          checks;
    int          fails;
    int          tests;
    int          tests_failed;
    int          fails_at_start;

    tb_clkgen u_clkgen (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    rdx_top #(.MEM_KEY(MEM_KEY), .LFSR_KEY(32'h1d87_2b41)) u_rdx_top (.*);

    //////////////////////////////////////////////////
    // Register port tasks, inputs change 1 ns after the edge
    //////////////////////////////////////////////////

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = 4'hF;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        @(posedge aclk);
        while (!s_axil_awready) @(posedge aclk);
        // Address and data are accepted in the same cycle
        expect_eq("wready with awready", 32'h1, 32'(s_axil_wready));
        #1;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        @(posedge aclk);
        while (!s_axil_bvalid) @(posedge aclk);
        resp = s_axil_bresp;
        #1;
        s_axil_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        @(posedge aclk);
        while (!s_axil_arready) @(posedge aclk);
        #1;
        s_axil_arvalid = 1'b0;
        @(posedge aclk);
        while (!s_axil_rvalid) @(posedge aclk);
        data = s_axil_rdata;
        resp = s_axil_rresp;
        #1;
        s_axil_rready = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Checks and reporting
    //////////////////////////////////////////////////

    task automatic expect_eq(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
            fails++;
        end
    endtask

    task automatic expect_true(input string name, input string what, input bit cond);
        checks++;
        assert (cond) else begin
            $display("[FAIL] %s: %s", name, what);
            fails++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (fails == fails_at_start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, fails - fails_at_start);
        end
        fails_at_start = fails;
    endtask

    // error must stay low for the whole clean run
    a_clean_no_error: assert property (
        @(posedge aclk) disable iff (!clean_run) !error
    ) else begin
        $display("[FAIL] clean_traffic error: expected 0, actual 1");
        fails++;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] data;
        logic [31:0] beats_a;
        logic [31:0] beats_b;
        logic [1:0]  resp;
        int          run_len;

        s_axil_awvalid = 1'b0;
        s_axil_awaddr  = 8'h0;
        s_axil_awprot  = 3'b000;
        s_axil_wvalid  = 1'b0;
        s_axil_wdata   = 32'h0;
        s_axil_wstrb   = 4'h0;
        s_axil_bready  = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr  = 8'h0;
        s_axil_arprot  = 3'b000;
        s_axil_rready  = 1'b0;
        clean_run      = 1'b0;
        checks         = 0;
        fails          = 0;
        tests          = 0;
        tests_failed   = 0;
        fails_at_start = 0;
        void'($urandom(32'h5ea4));

        @(posedge aresetn);
        idle(1);

        // Reset values
        read_reg(CSR_CTRL, data, resp);
        expect_eq("reset CTRL", 32'h0, data);
        read_reg(CSR_KEY, data, resp);
        expect_eq("reset KEY", MEM_KEY, data);
        read_reg(CSR_TIMEOUT, data, resp);
        expect_eq("reset TIMEOUT", 32'd64, data);
        read_reg(CSR_STATUS, data, resp);
        expect_eq("reset STATUS", 32'h0, data);
        read_reg(CSR_BEATS, data, resp);
        expect_eq("reset BEATS", 32'h0, data);
        read_reg(CSR_ERRORS, data, resp);
        expect_eq("reset ERRORS", 32'h0, data);
        expect_eq("reset error", 32'h0, 32'(error));
        end_test("reset_values");

        // Register access
        write_reg(CSR_KEY, 32'hA5C3_0F96, resp);
        read_reg(CSR_KEY, data, resp);
        expect_eq("KEY readback", 32'hA5C3_0F96, data);
        write_reg(CSR_TIMEOUT, 32'h0000_1234, resp);
        read_reg(CSR_TIMEOUT, data, resp);
        expect_eq("TIMEOUT readback", 32'h0000_1234, data);
        read_reg(8'h20, data, resp);
        expect_eq("unmapped read resp", 32'(RESP_SLVERR), 32'(resp));
        write_reg(8'h20, 32'hFFFF_FFFF, resp);
        expect_eq("unmapped write resp", 32'(RESP_SLVERR), 32'(resp));
        write_reg(CSR_BEATS, 32'h0000_5555, resp);
        expect_eq("BEATS write resp", 32'(RESP_OKAY), 32'(resp));
        read_reg(CSR_BEATS, data, resp);
        expect_eq("BEATS after write", 32'h0, data);
        end_test("register_access");

        // Clean traffic with the matching key
        write_reg(CSR_KEY, MEM_KEY, resp);
        write_reg(CSR_TIMEOUT, 32'd64, resp);
        clean_run = 1'b1;
        write_reg(CSR_CTRL, 32'h1, resp);
        run_len = 200 + int'($urandom % 201);
        idle(run_len);
        read_reg(CSR_BEATS, beats_a, resp);
        expect_true("clean_traffic", "no read completed during the run", beats_a != 0);
        idle(50);
        read_reg(CSR_BEATS, beats_b, resp);
        expect_true("clean_traffic", "BEATS did not grow between two reads",
                    beats_b > beats_a);
        read_reg(CSR_ERRORS, data, resp);
        expect_eq("clean ERRORS", 32'h0, data);
        read_reg(CSR_STATUS, data, resp);
        expect_eq("clean STATUS", 32'h0, data);
        clean_run = 1'b0;
        end_test("clean_traffic");

        // Wrong key, only the rdata flag may rise
        write_reg(CSR_KEY, MEM_KEY ^ 32'h1, resp);
        write_reg(CSR_CTRL, 32'h1, resp);
        idle(100);
        read_reg(CSR_STATUS, data, resp);
        expect_eq("mismatch STATUS", 32'h0000_0004, data);
        read_reg(CSR_ERRORS, data, resp);
        expect_true("data_mismatch", "ERRORS stayed at zero", data != 0);
        expect_eq("mismatch error", 32'h1, 32'(error));
        end_test("data_mismatch");

        // Timeout limit of 1 cycle
        write_reg(CSR_KEY, MEM_KEY, resp);
        write_reg(CSR_TIMEOUT, 32'd1, resp);
        write_reg(CSR_CTRL, 32'h3, resp);
        run_len = 200 + int'($urandom % 201);
        idle(run_len);
        read_reg(CSR_STATUS, data, resp);
        // Bit 2 may hold leftovers from reads issued under the wrong key
        expect_eq("timeout flags", 32'h1, {30'h0, data[1:0]});
        end_test("timeout");

        // Clear after the traffic has drained
        write_reg(CSR_TIMEOUT, 32'd64, resp);
        write_reg(CSR_CTRL, 32'h0, resp);
        idle(20);
        read_reg(CSR_BEATS, beats_b, resp);
        do begin
            beats_a = beats_b;
            idle(40);
            read_reg(CSR_BEATS, beats_b, resp);
        end while (beats_b != beats_a);
        write_reg(CSR_CTRL, 32'h2, resp);
        idle(3);
        read_reg(CSR_STATUS, data, resp);
        expect_eq("clear STATUS", 32'h0, data);
        read_reg(CSR_BEATS, data, resp);
        expect_eq("clear BEATS", 32'h0, data);
        read_reg(CSR_ERRORS, data, resp);
        expect_eq("clear ERRORS", 32'h0, data);
        expect_eq("clear error", 32'h0, 32'(error));
        end_test("clear");

        $display("tests: %0d run, %0d failed; checks: %0d run, %0d failed",
                 tests, tests_failed, checks, fails);
        if (fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/rdx_pkg.sv
verilog/lfsr32.sv
verilog/rd_traffic_driver.sv
verilog/rd_pattern_mem.sv
verilog/rdx_csr.sv
verilog/rdx_top.sv
sim/tb_clkgen.sv
sim/tb_rdx.sv

// File: Makefile
# Build and run the read exerciser testbench with Verilator
TOP = tb_rdx

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "TEST RESULT: FAIL" >> sim.log
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
